/* verilog/dbg_cpu_pkg.sv */
/* Shared widths, command opcodes and counter sizes for the CPU debug module
   Data register views: command struct, burst payload struct and their union
   TDO source select encoding */

package dbg_cpu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  localparam int DATAREG_LEN = 57;   // TAP data register length
  localparam int ADDR_W      = 32;   // SPR address
  localparam int DATA_W      = 32;   // SPR data word
  localparam int COUNT_W     = 16;   // Burst word count
  localparam int CRC_W       = 32;
  localparam int BITCNT_W    = 6;    // Counts up to DATA_W inclusive

  // Reflected Ethernet polynomial, LSB first
  localparam logic [CRC_W-1:0] CRC_POLY = 32'hEDB8_8320;

  ////////////////////////////////////////////////////////////
  // Opcodes
  localparam logic [3:0] CMD_BWRITE32 = 4'd3;
  localparam logic [3:0] CMD_BREAD32  = 4'd7;
  localparam logic [3:0] CMD_IREG_WR  = 4'd9;
  localparam logic [3:0] CMD_IREG_SEL = 4'd13;

  // Index of the only internal register
  localparam int INTREG_STATUS = 0;

  ////////////////////////////////////////////////////////////
  // Data register views

  // Command as left in the register at Update-DR, MSB first
  typedef struct packed {
    logic               top_flag;  // 0 = command for this module
    logic [3:0]         opcode;
    logic [3:0]         select;    // Top 2 bits double as status data
    logic [ADDR_W-1:0]  address;
    logic [COUNT_W-1:0] count;
  } dbg_cmd_t;

  // Burst payload, newest bits shifted in at the top
  typedef struct packed {
    logic [DATA_W-1:0]             word;   // Data or CRC word
    logic [DATAREG_LEN-DATA_W-1:0] rsvd;   // Don't care
  } dbg_payload_t;

  typedef union packed {
    dbg_cmd_t     cmd;
    dbg_payload_t pay;
  } dbg_dreg_u;

  // TDO source
  typedef enum logic [1:0] {
    BIU_READY,
    DATA_OUT,
    CRC_MATCH,
    CRC_OUT
  } tdo_sel_e;

endpackage

/* verilog/dbg_ifs.sv */
/* Internal interfaces of the CPU debug module
   dbg_ctrl_if: burst controller to shift/CRC datapath
   dbg_bus_if: requesters to SPR bus interface unit */

`timescale 1ns/100ps

////////////////////////////////////////////////////////////
// Controller to datapath strobes
interface dbg_ctrl_if;
  import dbg_cpu_pkg::*;

  logic     out_load;     // Load shift register with bus read data
  logic     status_load;  // Load shift register with status word
  logic     out_shift;    // Shift toward TDO
  logic     crc_clr;      // Preset CRC to all ones
  logic     crc_en;       // Fold one bit into CRC
  logic     crc_in_tdi;   // 1 = tdi_i, 0 = shift register LSB
  logic     crc_shift;    // Shift CRC out on TDO
  tdo_sel_e tdo_sel;

  modport controller (
    output out_load, status_load, out_shift, crc_clr, crc_en,
           crc_in_tdi, crc_shift, tdo_sel
  );

  modport datapath (
    input  out_load, status_load, out_shift, crc_clr, crc_en,
           crc_in_tdi, crc_shift, tdo_sel
  );
endinterface

////////////////////////////////////////////////////////////
// One SPR access per strobe
interface dbg_bus_if;
  import dbg_cpu_pkg::*;

  logic              strobe;  // Single cycle, only while ready
  logic              rd;      // 1 = read, 0 = write
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;
  logic              ready;   // Unit idle, last access done

  modport requester (output strobe, rd, addr, wdata, input rdata, ready);
  modport unit      (input strobe, rd, addr, wdata, output rdata, ready);
endinterface

/* verilog/dbg_cmd_decode.sv */
/* Command decode for the CPU debug module
   Burst start detect and the two-bit stall/reset status register */

`timescale 1ns/100ps

module dbg_cmd_decode (
  input  logic                   tck_i,
  input  logic                   tlr_i,
  input  logic                   module_select_i,
  input  logic                   update_dr_i,
  input  dbg_cpu_pkg::dbg_dreg_u data_register_i,
  input  logic                   cpu_bp_i,
  output dbg_cpu_pkg::dbg_cmd_t  cmd_o,
  output logic                   burst_start_o,   // One cycle, at Update-DR
  output logic                   burst_rd_o,
  output logic [1:0]             status_o,        // {reset, stall}
  output logic                   cpu_stall_o,
  output logic                   cpu_rst_o
);
  import dbg_cpu_pkg::*;

  logic       cmd_upd;     // Update-DR with a command for us
  logic       ireg_cmd;    // Register write or register select
  logic       status_wr;
  logic [1:0] status_q;    // Bit 0 stall, bit 1 reset

  assign cmd_o   = data_register_i.cmd;
  assign cmd_upd = module_select_i & update_dr_i & ~cmd_o.top_flag;

  assign burst_start_o = cmd_upd & ((cmd_o.opcode == CMD_BWRITE32) |
                                    (cmd_o.opcode == CMD_BREAD32));
  assign burst_rd_o    = (cmd_o.opcode == CMD_BREAD32);

  // Opcode bit 2 marks a select, which has only one register to pick
  assign ireg_cmd  = (cmd_o.opcode == CMD_IREG_WR) | (cmd_o.opcode == CMD_IREG_SEL);
  assign status_wr = cmd_upd & ireg_cmd & ~cmd_o.opcode[2];

  ////////////////////////////////////////////////////////////
  // Status register
  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      status_q <= 2'b00;
    else
    begin
      if (status_wr) status_q[1] <= cmd_o.select[3];         // CPU reset
      if (status_wr) status_q[0] <= cmd_o.select[2] | cpu_bp_i;
      else if (cpu_bp_i) status_q[0] <= 1'b1;                // Breakpoint stalls
    end
  end

  assign status_o    = status_q;
  assign cpu_stall_o = status_q[0];
  assign cpu_rst_o   = status_q[1];

endmodule

/* verilog/dbg_burst_ctrl.sv */
/* Burst controller for the CPU debug module
   Read/write burst FSM with operation, bit, word and address counters */

`timescale 1ns/100ps

module dbg_burst_ctrl (
  input  logic                  tck_i,
  input  logic                  tlr_i,
  input  logic                  module_select_i,
  input  logic                  capture_dr_i,
  input  logic                  shift_dr_i,
  input  logic                  update_dr_i,
  input  logic                  tdi_i,
  input  dbg_cpu_pkg::dbg_cmd_t cmd_i,
  input  logic                  burst_start_i,
  input  logic                  burst_rd_i,
  output logic                  top_inhibit_o,
  dbg_ctrl_if.controller        ctrl,
  dbg_bus_if.requester          bus
);
  import dbg_cpu_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_RBEGIN, ST_RREADY, ST_RSTATUS, ST_RBURST, ST_RCRC,
    ST_WREADY, ST_WWAIT, ST_WBURST, ST_WCRC, ST_WMATCH
  } state_e;

  state_e               state, next_state;
  logic                 rd_q;      // Operation of the current burst
  logic [ADDR_W-1:0]    addr_q;    // Address of next access
  logic [COUNT_W-1:0]   word_q;    // Words left
  logic [BITCNT_W-1:0]  bit_q;     // Bits of current word
  logic                 burst_ld, addr_inc, word_dec, bit_rst, bit_en;
  logic                 word_zero, word_more, bit_max, bit_full;

  assign word_zero = (word_q == '0);
  assign word_more = (word_q > COUNT_W'(1));           // Another access after this one
  assign bit_max   = (bit_q == BITCNT_W'(DATA_W - 1)); // Last bit of a word
  assign bit_full  = (bit_q == BITCNT_W'(DATA_W));     // Whole CRC received

  assign top_inhibit_o = (state != ST_IDLE);
  assign bus.rd        = rd_q;
  assign bus.addr      = addr_q;

  ////////////////////////////////////////////////////////////
  // State and counters
  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
    begin
      state  <= ST_IDLE;
      rd_q   <= 1'b0;
      addr_q <= '0;
      word_q <= '0;
      bit_q  <= '0;
    end
    else
    begin
      state <= next_state;
      if (burst_ld) rd_q <= burst_rd_i;
      if (burst_ld) addr_q <= cmd_i.address;
      else if (addr_inc) addr_q <= addr_q + ADDR_W'(1);  // SPRs are word addressed
      if (burst_ld) word_q <= cmd_i.count;
      else if (word_dec) word_q <= word_q - COUNT_W'(1);
      if (bit_rst) bit_q <= '0;
      else if (bit_en) bit_q <= bit_q + BITCNT_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state and strobes
  always_comb
  begin
    next_state       = state;
    burst_ld         = 1'b0;
    addr_inc         = 1'b0;
    word_dec         = 1'b0;
    bit_rst          = 1'b0;
    bit_en           = 1'b0;
    bus.strobe       = 1'b0;
    ctrl.out_load    = 1'b0;
    ctrl.status_load = 1'b0;
    ctrl.out_shift   = 1'b0;
    ctrl.crc_clr     = 1'b0;
    ctrl.crc_en      = 1'b0;
    ctrl.crc_in_tdi  = 1'b0;
    ctrl.crc_shift   = 1'b0;
    ctrl.tdo_sel     = DATA_OUT;

    case (state)
      ST_IDLE:
      begin
        ctrl.status_load = module_select_i & capture_dr_i;  // Status readback
        ctrl.out_shift   = module_select_i & shift_dr_i;
        if (burst_start_i)
        begin
          next_state   = burst_rd_i ? ST_RBEGIN : ST_WREADY;
          burst_ld     = 1'b1;
          bit_rst      = 1'b1;
          ctrl.crc_clr = 1'b1;
        end
      end

      ST_RBEGIN:
      begin
        if (word_zero) next_state = ST_IDLE;  // Empty burst
        else
        begin
          next_state = ST_RREADY;
          bus.strobe = 1'b1;                  // Fetch first word early
          addr_inc   = 1'b1;
        end
      end

      ST_RREADY:
        if (module_select_i & capture_dr_i) next_state = ST_RSTATUS;

      ST_RSTATUS:
      begin
        ctrl.tdo_sel = BIU_READY;             // Debugger polls this bit
        if (update_dr_i) next_state = ST_IDLE;
        else if (bus.ready)
        begin
          next_state    = ST_RBURST;
          ctrl.out_load = 1'b1;
          bit_rst       = 1'b1;
          word_dec      = 1'b1;
          bus.strobe    = word_more;
          addr_inc      = word_more;
        end
      end

      ST_RBURST:
      begin
        ctrl.out_shift = 1'b1;
        ctrl.crc_en    = 1'b1;                // CRC of bits as they leave on TDO
        bit_en         = 1'b1;
        if (update_dr_i) next_state = ST_IDLE;
        else if (bit_max)
        begin
          bit_rst = 1'b1;
          if (word_zero) next_state = ST_RCRC;
          else
          begin
            ctrl.out_load = 1'b1;             // Next word, already fetched
            word_dec      = 1'b1;
            bus.strobe    = word_more;
            addr_inc      = word_more;
          end
        end
      end

      ST_RCRC:
      begin
        ctrl.tdo_sel   = CRC_OUT;
        ctrl.crc_shift = 1'b1;
        if (update_dr_i) next_state = ST_IDLE;
      end

      ST_WREADY:
      begin
        if (word_zero) next_state = ST_IDLE;
        else if (module_select_i & capture_dr_i) next_state = ST_WWAIT;
      end

      ST_WWAIT:
      begin
        if (update_dr_i) next_state = ST_IDLE;
        else if (module_select_i & shift_dr_i & tdi_i)  // Start bit
        begin
          next_state = ST_WBURST;
          word_dec   = 1'b1;                  // Counts words after the current one
        end
      end

      ST_WBURST:
      begin
        bit_en          = 1'b1;
        ctrl.crc_en     = 1'b1;
        ctrl.crc_in_tdi = 1'b1;
        if (update_dr_i) next_state = ST_IDLE;
        else if (bit_max)
        begin
          bit_rst    = 1'b1;
          bus.strobe = 1'b1;                  // 32nd bit is on tdi_i now
          addr_inc   = 1'b1;
          if (word_zero) next_state = ST_WCRC;
          else word_dec = 1'b1;
        end
      end

      ST_WCRC:
      begin
        bit_en = 1'b1;
        if (update_dr_i) next_state = ST_IDLE;
        else if (bit_full)
        begin
          next_state   = ST_WMATCH;
          ctrl.tdo_sel = CRC_MATCH;           // Bit right after the CRC
        end
      end

      ST_WMATCH:
      begin
        ctrl.tdo_sel = CRC_MATCH;
        if (update_dr_i) next_state = ST_IDLE;
      end

      default: next_state = ST_IDLE;
    endcase
  end

endmodule

/* verilog/dbg_shift_crc.sv */
/* Datapath of the CPU debug module
   Output shift register, serial CRC-32, CRC match and TDO select */

`timescale 1ns/100ps

module dbg_shift_crc (
  input  logic                   tck_i,
  input  logic                   tlr_i,
  input  logic                   tdi_i,
  input  dbg_cpu_pkg::dbg_dreg_u data_register_i,
  input  logic [1:0]             status_i,
  output logic                   module_tdo_o,
  dbg_ctrl_if.datapath           ctrl,
  dbg_bus_if.requester           bus
);
  import dbg_cpu_pkg::*;

  logic [DATA_W-1:0] out_q;        // Parallel load, shifts out LSB first
  logic [DATA_W-1:0] status_word;
  logic [CRC_W-1:0]  crc_q;
  logic              crc_bit;      // Bit entering the CRC
  logic              crc_fb;
  logic              crc_match;

  always_comb
  begin
    status_word = '0;
    status_word[2*INTREG_STATUS +: 2] = status_i;
  end

  ////////////////////////////////////////////////////////////
  // Output shift register
  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      out_q <= '0;
    else if (ctrl.status_load)
      out_q <= status_word;
    else if (ctrl.out_load)                  // Wins over the shift at word end
      out_q <= bus.rdata;
    else if (ctrl.out_shift)
      out_q <= {1'b0, out_q[DATA_W-1:1]};
  end

  // Write word: 31 bits already in the register plus the one on tdi_i
  assign bus.wdata = {tdi_i, data_register_i.pay.word[DATA_W-1:1]};

  ////////////////////////////////////////////////////////////
  // Serial CRC-32
  assign crc_bit = ctrl.crc_in_tdi ? tdi_i : out_q[0];
  assign crc_fb  = crc_q[0] ^ crc_bit;

  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      crc_q <= '1;
    else if (ctrl.crc_clr)
      crc_q <= '1;                           // Preset, no final inversion
    else if (ctrl.crc_en)
      crc_q <= (crc_q >> 1) ^ (crc_fb ? CRC_POLY : '0);
    else if (ctrl.crc_shift)
      crc_q <= crc_q >> 1;                   // Register is its own output shifter
  end

  // Received CRC sits in the payload word once all 32 bits are in
  assign crc_match = (data_register_i.pay.word == crc_q);

  ////////////////////////////////////////////////////////////
  // TDO select
  always_comb
  begin
    case (ctrl.tdo_sel)
      BIU_READY: module_tdo_o = bus.ready;
      DATA_OUT:  module_tdo_o = out_q[0];
      CRC_MATCH: module_tdo_o = crc_match;
      default:   module_tdo_o = crc_q[0];
    endcase
  end

endmodule

/* verilog/dbg_spr_bus.sv */
/* Bus interface unit for the CPU SPR bus
   One strobe/ack access per request strobe */

`timescale 1ns/100ps

module dbg_spr_bus (
  input  logic                           tck_i,
  input  logic                           tlr_i,
  input  logic [dbg_cpu_pkg::DATA_W-1:0] cpu_data_i,
  input  logic                           cpu_ack_i,
  output logic [dbg_cpu_pkg::ADDR_W-1:0] cpu_addr_o,
  output logic [dbg_cpu_pkg::DATA_W-1:0] cpu_data_o,
  output logic                           cpu_stb_o,
  output logic                           cpu_we_o,
  dbg_bus_if.unit                        bus
);
  import dbg_cpu_pkg::*;

  logic              req;       // Accepted request
  logic              done;      // Acknowledge of current access
  logic [DATA_W-1:0] rdata_q;

  assign req  = bus.strobe & bus.ready;
  assign done = cpu_stb_o & cpu_ack_i;

  ////////////////////////////////////////////////////////////
  // Handshake
  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
    begin
      cpu_stb_o <= 1'b0;
      cpu_we_o  <= 1'b0;
    end
    else if (req)
    begin
      cpu_stb_o <= 1'b1;        // Held until acknowledged
      cpu_we_o  <= ~bus.rd;
    end
    else if (done)
    begin
      cpu_stb_o <= 1'b0;
      cpu_we_o  <= 1'b0;
    end
  end

  // Ready again on the cycle after the acknowledge
  assign bus.ready = ~cpu_stb_o;

  ////////////////////////////////////////////////////////////
  // Address and data
  always_ff @(posedge tck_i)
  begin
    if (req)
    begin
      cpu_addr_o <= bus.addr;
      cpu_data_o <= bus.wdata;
    end
    if (done & ~cpu_we_o)
      rdata_q <= cpu_data_i;    // Read data for the output shift register
  end

  assign bus.rdata = rdata_q;

endmodule

/* verilog/dbg_cpu_module.sv */
/* Top level of the JTAG CPU debug module
   Command decode, burst control, shift/CRC datapath and SPR bus unit */

`timescale 1ns/100ps

module dbg_cpu_module (
  input  logic                                tck_i,
  input  logic                                tlr_i,
  input  logic                                tdi_i,
  output logic                                module_tdo_o,
  input  logic                                capture_dr_i,
  input  logic                                shift_dr_i,
  input  logic                                update_dr_i,
  input  logic [dbg_cpu_pkg::DATAREG_LEN-1:0] data_register_i,
  input  logic                                module_select_i,
  output logic                                top_inhibit_o,
  // CPU SPR bus
  output logic [dbg_cpu_pkg::ADDR_W-1:0]      cpu_addr_o,
  input  logic [dbg_cpu_pkg::DATA_W-1:0]      cpu_data_i,
  output logic [dbg_cpu_pkg::DATA_W-1:0]      cpu_data_o,
  input  logic                                cpu_bp_i,
  output logic                                cpu_stall_o,
  output logic                                cpu_rst_o,
  output logic                                cpu_stb_o,
  output logic                                cpu_we_o,
  input  logic                                cpu_ack_i
);
  import dbg_cpu_pkg::*;

  dbg_dreg_u  dreg;
  dbg_cmd_t   cmd;
  logic       cmd_sel;       // Commands only taken while no burst runs
  logic       burst_start, burst_rd;
  logic [1:0] status;

  assign dreg    = data_register_i;
  assign cmd_sel = module_select_i & ~top_inhibit_o;

  dbg_ctrl_if ctrl_if ();
  dbg_bus_if  bus_if ();

  dbg_cmd_decode u_decode (
    .tck_i, .tlr_i, .module_select_i(cmd_sel), .update_dr_i,
    .data_register_i(dreg), .cpu_bp_i, .cmd_o(cmd),
    .burst_start_o(burst_start), .burst_rd_o(burst_rd),
    .status_o(status), .cpu_stall_o, .cpu_rst_o);

  dbg_burst_ctrl u_ctrl (
    .tck_i, .tlr_i, .module_select_i, .capture_dr_i, .shift_dr_i,
    .update_dr_i, .tdi_i, .cmd_i(cmd), .burst_start_i(burst_start),
    .burst_rd_i(burst_rd), .top_inhibit_o, .ctrl(ctrl_if), .bus(bus_if));

  dbg_shift_crc u_datapath (
    .tck_i, .tlr_i, .tdi_i, .data_register_i(dreg), .status_i(status),
    .module_tdo_o, .ctrl(ctrl_if), .bus(bus_if));

  dbg_spr_bus u_biu (
    .tck_i, .tlr_i, .cpu_data_i, .cpu_ack_i, .cpu_addr_o, .cpu_data_o,
    .cpu_stb_o, .cpu_we_o, .bus(bus_if));

endmodule

/* verification/dbg_cpu_properties.sv */
/* Bound assertions for the CPU debug module
   SPR bus handshake and top inhibit around idle */

`timescale 1ns/100ps

module dbg_cpu_properties (
  input logic tck_i,
  input logic tlr_i,
  input logic stb_i,        // CPU strobe
  input logic ack_i,
  input logic strobe_i,     // Request strobe to the bus unit
  input logic ready_i,
  input logic start_i,      // Burst start from the command decoder
  input logic inhibit_i
);

  // CPU strobe held until acknowledged
  a_stb_hold: assert property (@(posedge tck_i) disable iff (tlr_i)
    stb_i && !ack_i |=> stb_i)
    else $error("cpu_stb_o dropped before acknowledge");

  a_strobe_ready: assert property (@(posedge tck_i) disable iff (tlr_i)
    strobe_i |-> ready_i)
    else $error("bus strobe while unit busy");

  // Idle is left only through a burst start
  a_idle_inhibit: assert property (@(posedge tck_i) disable iff (tlr_i)
    !inhibit_i && !start_i |=> !inhibit_i)
    else $error("top_inhibit_o rose without a burst start");

  a_start_inhibit: assert property (@(posedge tck_i) disable iff (tlr_i)
    start_i |=> inhibit_i)
    else $error("top_inhibit_o low after a burst start");

endmodule

bind dbg_spr_bus dbg_cpu_properties u_bus_props (
  .tck_i, .tlr_i, .stb_i(cpu_stb_o), .ack_i(cpu_ack_i), .strobe_i(bus.strobe),
  .ready_i(bus.ready), .start_i(1'b0), .inhibit_i(1'b0));

bind dbg_burst_ctrl dbg_cpu_properties u_ctrl_props (
  .tck_i, .tlr_i, .stb_i(1'b0), .ack_i(1'b0), .strobe_i(bus.strobe),
  .ready_i(bus.ready), .start_i(burst_start_i), .inhibit_i(top_inhibit_o));

/* verification/tb_dbg_cpu_module.sv */
/* Testbench for the JTAG CPU debug module
   Clock, reset, SPR memory model, TAP helper tasks, directed tests, summary */

`timescale 1ns/100ps

module tb_dbg_cpu_module;
  import dbg_cpu_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;  // Tests need about 1200 cycles
  localparam int NWORDS         = 4;

  logic                   tck_i = 1'b0;
  logic                   tlr_i;
  logic                   tdi_i, capture_dr_i, shift_dr_i, update_dr_i;
  logic                   module_select_i, cpu_bp_i, cpu_ack_i;
  logic [DATAREG_LEN-1:0] data_register_i;
  logic [DATA_W-1:0]      cpu_data_i;
  logic                   module_tdo_o, top_inhibit_o;
  logic [ADDR_W-1:0]      cpu_addr_o;
  logic [DATA_W-1:0]      cpu_data_o;
  logic                   cpu_stall_o, cpu_rst_o, cpu_stb_o, cpu_we_o;

  logic [DATA_W-1:0]      spr_mem [0:255];   // SPR space seen by the debugger
  logic [DATA_W-1:0]      wr_data [0:NWORDS-1];
  logic [ADDR_W-1:0]      wr_addr;
  int                     errors = 0;
  int                     checks = 0;
  int                     cycle_cnt = 0;
  int unsigned            seed_val;

  dbg_cpu_module dut0 (.*);

  always #50 tck_i = ~tck_i;

  ////////////////////////////////////////////////////////////
  // SPR memory model, ack after 1 to 4 cycles
  always
  begin
    int ack_delay;
    @(posedge tck_i);
    #10;
    if (cpu_stb_o === 1'b1)
    begin
      ack_delay = int'($urandom_range(4, 1));
      repeat (ack_delay - 1)
      begin
        @(posedge tck_i);
        #10;
      end
      if (cpu_we_o) spr_mem[cpu_addr_o[7:0]] = cpu_data_o;
      else cpu_data_i = spr_mem[cpu_addr_o[7:0]];
      cpu_ack_i = 1'b1;
      @(posedge tck_i);
      #10;
      cpu_ack_i = 1'b0;
    end
  end

  // Run limit
  always @(posedge tck_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input logic [1:0] exp,
                              input logic [1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // TAP model, called 10 ns after a rising edge
  task automatic tap_cycle(input logic cap, input logic sh, input logic upd,
                           input logic tdi, output logic tdo);
    capture_dr_i = cap;
    shift_dr_i   = sh;
    update_dr_i  = upd;
    tdi_i        = tdi;
    @(negedge tck_i);
    tdo = module_tdo_o;                       // Mid cycle, stable
    @(posedge tck_i);
    #10;
    if (sh) data_register_i = {tdi, data_register_i[DATAREG_LEN-1:1]};
    capture_dr_i = 1'b0;
    shift_dr_i   = 1'b0;
    update_dr_i  = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    logic tdo;
    repeat (n) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, tdo);
  endtask

  // Capture, shift 57 command bits LSB first, update
  task automatic send_command(input logic [3:0] opcode, input logic [3:0] sel,
                              input logic [ADDR_W-1:0] addr, input logic [COUNT_W-1:0] cnt);
    dbg_cmd_t cmd;
    logic     tdo;
    cmd = '{top_flag: 1'b0, opcode: opcode, select: sel, address: addr, count: cnt};
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);
    for (int i = 0; i < DATAREG_LEN; i++) tap_cycle(1'b0, 1'b1, 1'b0, cmd[i], tdo);
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
  endtask

  task automatic read_status(output logic [1:0] st);
    logic tdo;
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
    st[0] = tdo;                              // Stall first
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
    st[1] = tdo;
  endtask

  // Reference CRC-32, one bit, reflected and preset to ones
  function automatic logic [CRC_W-1:0] crc_bit(input logic [CRC_W-1:0] crc, input logic b);
    return (crc >> 1) ^ ((crc[0] ^ b) ? 32'hEDB8_8320 : 32'h0);
  endfunction

  ////////////////////////////////////////////////////////////
  // Burst helpers
  task automatic write_burst(input logic [ADDR_W-1:0] addr, input logic [4:0] flip_bit,
                             input logic do_flip, output logic match);
    logic [CRC_W-1:0] crc;
    logic             tdo;
    crc = '1;
    send_command(CMD_BWRITE32, 4'h0, addr, COUNT_W'(NWORDS));
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b1, tdo);   // Start bit
    for (int w = 0; w < NWORDS; w++)
      for (int b = 0; b < DATA_W; b++)
      begin
        crc = crc_bit(crc, wr_data[w][b]);
        tap_cycle(1'b0, 1'b1, 1'b0, wr_data[w][b], tdo);
      end
    if (do_flip) crc[flip_bit] = ~crc[flip_bit];
    for (int b = 0; b < CRC_W; b++) tap_cycle(1'b0, 1'b1, 1'b0, crc[b], tdo);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, match);
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
    idle_cycles(2);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  task automatic test_reset_state();
    check_bit("reset top_inhibit_o", 1'b0, top_inhibit_o);
    check_bit("reset cpu_stb_o", 1'b0, cpu_stb_o);
    check_bit("reset cpu_stall_o", 1'b0, cpu_stall_o);
    check_bit("reset cpu_rst_o", 1'b0, cpu_rst_o);
  endtask

  task automatic test_status_reg();
    logic [1:0] st;
    send_command(CMD_IREG_WR, 4'b0100, '0, '0);   // select[2] is stall
    check_bit("status cpu_stall_o", 1'b1, cpu_stall_o);
    check_bit("status cpu_rst_o", 1'b0, cpu_rst_o);
    read_status(st);
    check_status("status readback", 2'b01, st);
    send_command(CMD_IREG_WR, 4'b0000, '0, '0);
    check_bit("status stall cleared", 1'b0, cpu_stall_o);
    cpu_bp_i = 1'b1;
    idle_cycles(1);
    cpu_bp_i = 1'b0;
    check_bit("status breakpoint stall", 1'b1, cpu_stall_o);
  endtask

  task automatic test_write_burst();
    logic match;
    wr_addr = ADDR_W'($urandom_range(250, 0));
    for (int w = 0; w < NWORDS; w++) wr_data[w] = $urandom;
    write_burst(wr_addr, 5'd0, 1'b0, match);
    check_bit("write crc match", 1'b1, match);
    check_bit("write back to idle", 1'b0, top_inhibit_o);
    for (int w = 0; w < NWORDS; w++)
      check_word("write memory word", wr_data[w], spr_mem[wr_addr[7:0] + 8'(w)]);
  endtask

  task automatic test_write_bad_crc();
    logic match;
    write_burst(wr_addr, 5'd13, 1'b1, match);
    check_bit("bad crc match", 1'b0, match);
  endtask

  task automatic test_read_burst();
    logic [CRC_W-1:0]  crc;
    logic [DATA_W-1:0] exp, word, rx_crc;
    logic              tdo;
    int                polls;
    crc   = '1;
    polls = 0;
    send_command(CMD_BREAD32, 4'h0, wr_addr, COUNT_W'(NWORDS));
    idle_cycles(1);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);
    tdo = 1'b0;
    while (!tdo && polls < 64)
    begin
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
      polls++;
    end
    if (!tdo)
    begin
      errors++;
      $display("Read burst: ready bit never seen on TDO");
    end
    for (int w = 0; w < NWORDS; w++)
    begin
      exp = spr_mem[wr_addr[7:0] + 8'(w)];
      for (int b = 0; b < DATA_W; b++)
      begin
        tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
        word[b] = tdo;
        crc = crc_bit(crc, exp[b]);
      end
      check_word("read data word", exp, word);
    end
    for (int b = 0; b < CRC_W; b++)
    begin
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
      rx_crc[b] = tdo;
    end
    check_word("read crc", crc, rx_crc);
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
    idle_cycles(2);
    check_bit("read back to idle", 1'b0, top_inhibit_o);
  endtask

  task automatic test_zero_count();
    logic [1:0] st;
    send_command(CMD_BWRITE32, 4'h0, wr_addr, '0);
    idle_cycles(2);
    check_bit("zero write idle", 1'b0, top_inhibit_o);
    send_command(CMD_BREAD32, 4'h0, wr_addr, '0);
    idle_cycles(2);
    check_bit("zero read idle", 1'b0, top_inhibit_o);
    read_status(st);
    check_status("zero count status", 2'b01, st);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  initial
  begin
    seed_val        = $urandom(32440);
    tlr_i           = 1'b1;
    tdi_i           = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b1;                   // Only this module on the TAP
    cpu_bp_i        = 1'b0;
    cpu_ack_i       = 1'b0;
    cpu_data_i      = '0;
    data_register_i = '0;
    for (int i = 0; i < 256; i++)
      spr_mem[i] = {~i[7:0], i[7:0], 8'h5A, i[7:0] ^ 8'h3C};
    repeat (8) @(posedge tck_i);
    #10;
    tlr_i = 1'b0;
    idle_cycles(2);

    test_reset_state();
    test_status_reg();
    test_write_burst();
    test_write_bad_crc();
    test_read_burst();
    test_zero_count();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* filelist.f */
verilog/dbg_cpu_pkg.sv
verilog/dbg_ifs.sv
verilog/dbg_cmd_decode.sv
verilog/dbg_burst_ctrl.sv
verilog/dbg_shift_crc.sv
verilog/dbg_spr_bus.sv
verilog/dbg_cpu_module.sv
verification/dbg_cpu_properties.sv
verification/tb_dbg_cpu_module.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CPU debug module testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dbg_cpu_module -f filelist.f \
  --Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
else
  exit 1
fi
